/* source/lsu_cfg.svh */
// load/store memory parameters
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// byte address width
`define LSU_ADDR_WIDTH 32

// power-of-two count of 32-bit words in the data memory
`define LSU_MEM_WORDS 256

`endif

/* source/lsu_pkg.sv */
// load/store unit types
package lsu_pkg;

    `include "lsu_cfg.svh"

    typedef logic [31:0] word_t;
    typedef logic [`LSU_ADDR_WIDTH-1:0] addr_t;

    typedef enum logic [2:0] {
        MOP_LB  = 3'd0,
        MOP_LBU = 3'd1,
        MOP_LH  = 3'd2,
        MOP_LHU = 3'd3,
        MOP_LW  = 3'd4,
        MOP_SB  = 3'd5,
        MOP_SH  = 3'd6,
        MOP_SW  = 3'd7
    } mem_op_t;

    typedef logic [1:0] axi_resp_t;
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        ERR_NONE        = 2'd0,
        ERR_LOAD_ALIGN  = 2'd1,
        ERR_STORE_ALIGN = 2'd2,
        ERR_BUS         = 2'd3
    } lsu_err_t;

endpackage

/* source/load_extract.sv */
// load data extraction
`timescale 1ns/1ps

module load_extract (
    input  lsu_pkg::word_t   rword,
    input  logic [1:0]       byte_sel,
    input  lsu_pkg::mem_op_t op,
    output lsu_pkg::word_t   rdata
);
    import lsu_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // lane picked by the low address bits
    assign sel_byte = rword[{byte_sel, 3'b000} +: 8];
    assign sel_half = byte_sel[1] ? rword[31:16] : rword[15:0];

    always_comb begin
        case (op)
            MOP_LB: begin
                rdata = {{24{sel_byte[7]}}, sel_byte};
            end
            MOP_LBU: begin
                rdata = {24'b0, sel_byte};
            end
            MOP_LH: begin
                rdata = {{16{sel_half[15]}}, sel_half};
            end
            MOP_LHU: begin
                rdata = {16'b0, sel_half};
            end
            default: begin
                // full word for lw
                rdata = rword;
            end
        endcase
    end

endmodule

/* source/store_align.sv */
// store data lane placement
`timescale 1ns/1ps

module store_align (
    input  lsu_pkg::word_t   wdata_in,
    input  logic [1:0]       byte_sel,
    input  lsu_pkg::mem_op_t op,
    output lsu_pkg::word_t   wdata,
    output logic [3:0]       wstrb
);
    import lsu_pkg::*;

    always_comb begin
        case (op)
            MOP_SB: begin
                // byte copied to every lane and the strobe picks one
                wdata = {4{wdata_in[7:0]}};
                wstrb = 4'b0001 << byte_sel;
            end
            MOP_SH: begin
                wdata = {2{wdata_in[15:0]}};
                wstrb = byte_sel[1] ? 4'b1100 : 4'b0011;
            end
            MOP_SW: begin
                wdata = wdata_in;
                wstrb = 4'b1111;
            end
            default: begin
                // loads write nothing
                wdata = '0;
                wstrb = 4'b0000;
            end
        endcase
    end

endmodule

/* source/agu.sv */
// address generation unit
`timescale 1ns/1ps

module agu (
    input  logic             clk,
    input  logic             reset,
    input  logic             load,
    input  lsu_pkg::mem_op_t op,
    input  lsu_pkg::word_t   base,
    input  lsu_pkg::word_t   offset,
    input  lsu_pkg::word_t   wdata_in,
    input  lsu_pkg::word_t   rword,
    output lsu_pkg::addr_t   addr,
    output logic             misaligned,
    output lsu_pkg::word_t   rdata,
    output lsu_pkg::word_t   wdata,
    output logic [3:0]       wstrb
);
    import lsu_pkg::*;

    mem_op_t op_q;
    word_t   wdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            addr <= '0;
            op_q <= MOP_LW;
        end else if (load) begin
            addr <= addr_t'(base + offset);
            op_q <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            wdata_q <= wdata_in;
        end
    end

    always_comb begin
        case (op_q)
            MOP_LH, MOP_LHU, MOP_SH: misaligned = addr[0];
            MOP_LW, MOP_SW:          misaligned = |addr[1:0];
            default:                 misaligned = 1'b0;
        endcase
    end

    load_extract u_load_extract (
        .rword(rword), .byte_sel(addr[1:0]), .op(op_q), .rdata(rdata)
    );

    store_align u_store_align (
        .wdata_in(wdata_q), .byte_sel(addr[1:0]), .op(op_q), .wdata(wdata), .wstrb(wstrb)
    );

endmodule

/* source/lsu_port.sv */
// load/store port controller
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_port (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    output logic                req_ready,
    input  logic [2:0]          req_op,
    input  lsu_pkg::word_t      req_base,
    input  lsu_pkg::word_t      req_offset,
    input  lsu_pkg::word_t      req_wdata,
    output logic                resp_valid,
    output lsu_pkg::word_t      resp_rdata,
    output lsu_pkg::lsu_err_t   resp_err,
    output lsu_pkg::addr_t      awaddr,
    output logic                awvalid,
    input  logic                awready,
    output lsu_pkg::word_t      wdata,
    output logic [3:0]          wstrb,
    output logic                wvalid,
    input  logic                wready,
    input  lsu_pkg::axi_resp_t  bresp,
    input  logic                bvalid,
    output logic                bready,
    output lsu_pkg::addr_t      araddr,
    output logic                arvalid,
    input  logic                arready,
    input  lsu_pkg::word_t      rdata,
    input  lsu_pkg::axi_resp_t  rresp,
    input  logic                rvalid,
    output logic                rready
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_CHECK, S_RD_WAIT, S_WR_WAIT, S_RESP} state_t;

    state_t state;
    logic   rd_req;
    logic   wr_req;
    addr_t  eff_addr;
    logic   misaligned;
    word_t  ld_data;

    agu u_agu (
        .clk(clk), .reset(reset), .load(req_valid && req_ready), .op(mem_op_t'(req_op)),
        .base(req_base), .offset(req_offset), .wdata_in(req_wdata), .rword(rdata),
        .addr(eff_addr), .misaligned(misaligned), .rdata(ld_data), .wdata(wdata), .wstrb(wstrb)
    );

    assign req_ready  = (state == S_IDLE);
    assign resp_valid = (state == S_RESP);
    assign awaddr     = {eff_addr[`LSU_ADDR_WIDTH-1:2], 2'b00};
    assign araddr     = {eff_addr[`LSU_ADDR_WIDTH-1:2], 2'b00};
    assign awvalid    = wr_req;
    assign wvalid     = wr_req;
    assign arvalid    = rd_req;
    assign bready     = (state == S_WR_WAIT);
    assign rready     = (state == S_RD_WAIT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= S_IDLE;
            rd_req <= 1'b0;
            wr_req <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (req_valid) state <= S_CHECK;
                S_CHECK: begin
                    // stores always carry a nonzero strobe
                    if (misaligned) begin
                        state <= S_RESP;
                    end else if (|wstrb) begin
                        state  <= S_WR_WAIT;
                        wr_req <= 1'b1;
                    end else begin
                        state  <= S_RD_WAIT;
                        rd_req <= 1'b1;
                    end
                end
                S_RD_WAIT: begin
                    if (arvalid && arready) rd_req <= 1'b0;
                    if (rvalid) state <= S_RESP;
                end
                S_WR_WAIT: begin
                    if (awvalid && awready && wready) wr_req <= 1'b0;
                    if (bvalid) state <= S_RESP;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_CHECK) begin
            // alignment error unless a bus response replaces it
            resp_rdata <= '0;
            if (|wstrb) resp_err <= ERR_STORE_ALIGN;
            else resp_err <= ERR_LOAD_ALIGN;
        end else if (state == S_RD_WAIT && rvalid) begin
            if (rresp == RESP_SLVERR) begin
                resp_rdata <= '0;
                resp_err   <= ERR_BUS;
            end else begin
                resp_rdata <= ld_data;
                resp_err   <= ERR_NONE;
            end
        end else if (state == S_WR_WAIT && bvalid) begin
            resp_rdata <= '0;
            if (bresp == RESP_SLVERR) resp_err <= ERR_BUS;
            else resp_err <= ERR_NONE;
        end
    end

endmodule

/* source/axil_arbiter.sv */
// two-master AXI4-Lite arbiter
`timescale 1ns/1ps

module axil_arbiter (
    input  logic                clk,
    input  logic                reset,
    input  lsu_pkg::addr_t      m0_awaddr, m0_araddr,
    input  lsu_pkg::word_t      m0_wdata,
    input  logic [3:0]          m0_wstrb,
    input  logic                m0_awvalid, m0_wvalid, m0_bready, m0_arvalid, m0_rready,
    output logic                m0_awready, m0_wready, m0_bvalid, m0_arready, m0_rvalid,
    output lsu_pkg::axi_resp_t  m0_bresp, m0_rresp,
    output lsu_pkg::word_t      m0_rdata,
    input  lsu_pkg::addr_t      m1_awaddr, m1_araddr,
    input  lsu_pkg::word_t      m1_wdata,
    input  logic [3:0]          m1_wstrb,
    input  logic                m1_awvalid, m1_wvalid, m1_bready, m1_arvalid, m1_rready,
    output logic                m1_awready, m1_wready, m1_bvalid, m1_arready, m1_rvalid,
    output lsu_pkg::axi_resp_t  m1_bresp, m1_rresp,
    output lsu_pkg::word_t      m1_rdata,
    output lsu_pkg::addr_t      s_awaddr, s_araddr,
    output lsu_pkg::word_t      s_wdata,
    output logic [3:0]          s_wstrb,
    output logic                s_awvalid, s_wvalid, s_bready, s_arvalid, s_rready,
    input  logic                s_awready, s_wready, s_bvalid, s_arready, s_rvalid,
    input  lsu_pkg::axi_resp_t  s_bresp, s_rresp,
    input  lsu_pkg::word_t      s_rdata
);

    logic busy;
    logic owner;
    logic last_winner;
    logic req0;
    logic req1;
    logic pick;
    logic sel0;
    logic sel1;

    assign req0 = m0_arvalid | m0_awvalid;
    assign req1 = m1_arvalid | m1_awvalid;
    // on a tie the master that lost last time wins
    assign pick = (req0 && req1) ? ~last_winner : req1;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy        <= 1'b0;
            owner       <= 1'b0;
            last_winner <= 1'b1;
        end else if (!busy) begin
            if (req0 || req1) begin
                busy        <= 1'b1;
                owner       <= pick;
                last_winner <= pick;
            end
        end else if ((s_bvalid && s_bready) || (s_rvalid && s_rready)) begin
            busy <= 1'b0;
        end
    end

    assign sel0 = busy & ~owner;
    assign sel1 = busy & owner;

    // request channels from the owner
    assign s_awaddr  = owner ? m1_awaddr : m0_awaddr;
    assign s_araddr  = owner ? m1_araddr : m0_araddr;
    assign s_wdata   = owner ? m1_wdata : m0_wdata;
    assign s_wstrb   = owner ? m1_wstrb : m0_wstrb;
    assign s_awvalid = (sel0 & m0_awvalid) | (sel1 & m1_awvalid);
    assign s_wvalid  = (sel0 & m0_wvalid) | (sel1 & m1_wvalid);
    assign s_arvalid = (sel0 & m0_arvalid) | (sel1 & m1_arvalid);
    assign s_bready  = (sel0 & m0_bready) | (sel1 & m1_bready);
    assign s_rready  = (sel0 & m0_rready) | (sel1 & m1_rready);

    // handshakes only reach the owner
    assign m0_awready = sel0 & s_awready;
    assign m0_wready  = sel0 & s_wready;
    assign m0_arready = sel0 & s_arready;
    assign m0_bvalid  = sel0 & s_bvalid;
    assign m0_rvalid  = sel0 & s_rvalid;
    assign m1_awready = sel1 & s_awready;
    assign m1_wready  = sel1 & s_wready;
    assign m1_arready = sel1 & s_arready;
    assign m1_bvalid  = sel1 & s_bvalid;
    assign m1_rvalid  = sel1 & s_rvalid;

    assign m0_bresp = s_bresp;
    assign m0_rresp = s_rresp;
    assign m0_rdata = s_rdata;
    assign m1_bresp = s_bresp;
    assign m1_rresp = s_rresp;
    assign m1_rdata = s_rdata;

endmodule

/* source/data_ram.sv */
// AXI4-Lite word memory
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module data_ram (
    input  logic                clk,
    input  logic                reset,
    input  lsu_pkg::addr_t      s_awaddr,
    input  logic                s_awvalid,
    output logic                s_awready,
    input  lsu_pkg::word_t      s_wdata,
    input  logic [3:0]          s_wstrb,
    input  logic                s_wvalid,
    output logic                s_wready,
    output lsu_pkg::axi_resp_t  s_bresp,
    output logic                s_bvalid,
    input  logic                s_bready,
    input  lsu_pkg::addr_t      s_araddr,
    input  logic                s_arvalid,
    output logic                s_arready,
    output lsu_pkg::word_t      s_rdata,
    output lsu_pkg::axi_resp_t  s_rresp,
    output logic                s_rvalid,
    input  logic                s_rready
);
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);

    word_t            mem [0:`LSU_MEM_WORDS-1];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             wr_hit;
    logic             rd_hit;
    logic             wr_fire;
    logic             rd_fire;

    assign wr_idx = s_awaddr[IDX_W+1:2];
    assign rd_idx = s_araddr[IDX_W+1:2];
    // in range when no word index bit above the array is set
    assign wr_hit = ~|s_awaddr[`LSU_ADDR_WIDTH-1:IDX_W+2];
    assign rd_hit = ~|s_araddr[`LSU_ADDR_WIDTH-1:IDX_W+2];

    assign wr_fire   = s_awvalid && s_wvalid && !s_bvalid;
    assign s_awready = wr_fire;
    assign s_wready  = wr_fire;
    assign s_arready = !s_rvalid;
    assign rd_fire   = s_arvalid && s_arready;

    always_ff @(posedge clk) begin
        if (reset) begin
            s_bvalid <= 1'b0;
            s_rvalid <= 1'b0;
        end else begin
            if (wr_fire) s_bvalid <= 1'b1;
            else if (s_bready) s_bvalid <= 1'b0;
            if (rd_fire) s_rvalid <= 1'b1;
            else if (s_rready) s_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) s_bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        if (rd_fire) begin
            s_rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
            s_rdata <= rd_hit ? mem[rd_idx] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `LSU_MEM_WORDS; i++) mem[i] <= '0;
        end else if (wr_fire && wr_hit) begin
            for (int b = 0; b < 4; b++) begin
                if (s_wstrb[b]) mem[wr_idx][8*b +: 8] <= s_wdata[8*b +: 8];
            end
        end
    end

endmodule

/* source/mem_subsys_top.sv */
// dual-port load/store memory subsystem
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module mem_subsys_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        p0_req_valid,
    output logic        p0_req_ready,
    input  logic [2:0]  p0_req_op,
    input  logic [31:0] p0_req_base, p0_req_offset, p0_req_wdata,
    output logic        p0_resp_valid,
    output logic [31:0] p0_resp_rdata,
    output logic [1:0]  p0_resp_err,
    input  logic        p1_req_valid,
    output logic        p1_req_ready,
    input  logic [2:0]  p1_req_op,
    input  logic [31:0] p1_req_base, p1_req_offset, p1_req_wdata,
    output logic        p1_resp_valid,
    output logic [31:0] p1_resp_rdata,
    output logic [1:0]  p1_resp_err
);

    logic [`LSU_ADDR_WIDTH-1:0] m0_awaddr, m0_araddr, m1_awaddr, m1_araddr, s_awaddr, s_araddr;
    logic [31:0] m0_wdata, m0_rdata, m1_wdata, m1_rdata, s_wdata, s_rdata;
    logic [3:0]  m0_wstrb, m1_wstrb, s_wstrb;
    logic [1:0]  m0_bresp, m0_rresp, m1_bresp, m1_rresp, s_bresp, s_rresp;
    logic        m0_awvalid, m0_awready, m0_wvalid, m0_wready, m0_bvalid;
    logic        m0_bready, m0_arvalid, m0_arready, m0_rvalid, m0_rready;
    logic        m1_awvalid, m1_awready, m1_wvalid, m1_wready, m1_bvalid;
    logic        m1_bready, m1_arvalid, m1_arready, m1_rvalid, m1_rready;
    logic        s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid;
    logic        s_bready, s_arvalid, s_arready, s_rvalid, s_rready;

    lsu_port u_port0 (
        .clk(clk), .reset(reset),
        .req_valid(p0_req_valid), .req_ready(p0_req_ready), .req_op(p0_req_op),
        .req_base(p0_req_base), .req_offset(p0_req_offset), .req_wdata(p0_req_wdata),
        .resp_valid(p0_resp_valid), .resp_rdata(p0_resp_rdata), .resp_err(p0_resp_err),
        .awaddr(m0_awaddr), .awvalid(m0_awvalid), .awready(m0_awready),
        .wdata(m0_wdata), .wstrb(m0_wstrb), .wvalid(m0_wvalid), .wready(m0_wready),
        .bresp(m0_bresp), .bvalid(m0_bvalid), .bready(m0_bready),
        .araddr(m0_araddr), .arvalid(m0_arvalid), .arready(m0_arready),
        .rdata(m0_rdata), .rresp(m0_rresp), .rvalid(m0_rvalid), .rready(m0_rready)
    );

    lsu_port u_port1 (
        .clk(clk), .reset(reset),
        .req_valid(p1_req_valid), .req_ready(p1_req_ready), .req_op(p1_req_op),
        .req_base(p1_req_base), .req_offset(p1_req_offset), .req_wdata(p1_req_wdata),
        .resp_valid(p1_resp_valid), .resp_rdata(p1_resp_rdata), .resp_err(p1_resp_err),
        .awaddr(m1_awaddr), .awvalid(m1_awvalid), .awready(m1_awready),
        .wdata(m1_wdata), .wstrb(m1_wstrb), .wvalid(m1_wvalid), .wready(m1_wready),
        .bresp(m1_bresp), .bvalid(m1_bvalid), .bready(m1_bready),
        .araddr(m1_araddr), .arvalid(m1_arvalid), .arready(m1_arready),
        .rdata(m1_rdata), .rresp(m1_rresp), .rvalid(m1_rvalid), .rready(m1_rready)
    );

    // wire names match the port names of both blocks
    axil_arbiter u_arbiter (.*);

    data_ram u_data_ram (.*);

endmodule

/* verification/tb_mem_subsys.sv */
// memory subsystem testbench
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int MAX_TESTS  = 32;
    localparam int CLK_PERIOD = 4;

    logic        clk;
    logic        reset;
    logic        p0_req_valid;
    logic        p0_req_ready;
    logic [2:0]  p0_req_op;
    logic [31:0] p0_req_base;
    logic [31:0] p0_req_offset;
    logic [31:0] p0_req_wdata;
    logic        p0_resp_valid;
    logic [31:0] p0_resp_rdata;
    logic [1:0]  p0_resp_err;
    logic        p1_req_valid;
    logic        p1_req_ready;
    logic [2:0]  p1_req_op;
    logic [31:0] p1_req_base;
    logic [31:0] p1_req_offset;
    logic [31:0] p1_req_wdata;
    logic        p1_resp_valid;
    logic [31:0] p1_resp_rdata;
    logic [1:0]  p1_resp_err;

    // one entry per test line and port
    logic        t_en    [0:MAX_TESTS-1][0:1];
    logic [2:0]  t_op    [0:MAX_TESTS-1][0:1];
    logic [31:0] t_base  [0:MAX_TESTS-1][0:1];
    logic [31:0] t_off   [0:MAX_TESTS-1][0:1];
    logic [31:0] t_wdata [0:MAX_TESTS-1][0:1];
    logic [31:0] t_rdata [0:MAX_TESTS-1][0:1];
    logic [1:0]  t_err   [0:MAX_TESTS-1][0:1];
    int          n_tests = 0;

    int          resp_cnt [0:1] = '{0, 0};
    int          want_cnt [0:1];
    logic [31:0] got_rdata [0:1];
    logic [1:0]  got_err [0:1];

    mem_subsys_top u_mem_subsys_top (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // capture the one-cycle resp_valid pulse
    always @(posedge clk) begin
        if (p0_resp_valid) begin
            got_rdata[0] = p0_resp_rdata;
            got_err[0]   = p0_resp_err;
            resp_cnt[0]  = resp_cnt[0] + 1;
        end
    end

    always @(posedge clk) begin
        if (p1_resp_valid) begin
            got_rdata[1] = p1_resp_rdata;
            got_err[1]   = p1_resp_err;
            resp_cnt[1]  = resp_cnt[1] + 1;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic read_tests();
        int          fd;
        int          cnt;
        int          n;
        string       line;
        logic [31:0] f [0:13];
        fd = $fopen("verification/mem_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/mem_tests.txt");
            $display("SIMULATION FAILED");
            $fatal(1, "missing test file");
        end else begin
            cnt = 0;
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") continue;
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                            f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
                if (n != 14 || cnt >= MAX_TESTS) begin
                    $display("test file line cannot be used: %s", line);
                    $display("SIMULATION FAILED");
                    $fatal(1, "bad test file");
                end else begin
                    for (int p = 0; p < 2; p++) begin
                        t_en[cnt][p]    = f[7*p][0];
                        t_op[cnt][p]    = f[7*p+1][2:0];
                        t_base[cnt][p]  = f[7*p+2];
                        t_off[cnt][p]   = f[7*p+3];
                        t_wdata[cnt][p] = f[7*p+4];
                        t_rdata[cnt][p] = f[7*p+5];
                        t_err[cnt][p]   = f[7*p+6][1:0];
                    end
                    cnt++;
                end
            end
            $fclose(fd);
            n_tests = cnt;
        end
    endtask

    task automatic launch_pair(input int t);
        logic [1:0] pend;
        logic [1:0] go;
        pend          = {t_en[t][1], t_en[t][0]};
        p0_req_valid  = t_en[t][0];
        p0_req_op     = t_op[t][0];
        p0_req_base   = t_base[t][0];
        p0_req_offset = t_off[t][0];
        p0_req_wdata  = t_wdata[t][0];
        p1_req_valid  = t_en[t][1];
        p1_req_op     = t_op[t][1];
        p1_req_base   = t_base[t][1];
        p1_req_offset = t_off[t][1];
        p1_req_wdata  = t_wdata[t][1];
        while (pend != 2'b00) begin
            // ready is stable here and decides the handshake at the coming edge
            go   = pend & {p1_req_ready, p0_req_ready};
            pend = pend & ~go;
            @(posedge clk);
            #1;
            if (!pend[0]) p0_req_valid = 1'b0;
            if (!pend[1]) p1_req_valid = 1'b0;
            // a port stays busy from handshake until its response
            if (go[0]) begin
                check_value(p0_req_ready, 1'b0,
                            $sformatf("test %0d port 0 ready after handshake", t + 1));
            end
            if (go[1]) begin
                check_value(p1_req_ready, 1'b0,
                            $sformatf("test %0d port 1 ready after handshake", t + 1));
            end
        end
    endtask

    task automatic check_results(input int t);
        for (int p = 0; p < 2; p++) begin
            check_value(resp_cnt[p], want_cnt[p],
                        $sformatf("test %0d port %0d responses", t + 1, p));
            if (t_en[t][p]) begin
                check_value(got_rdata[p], t_rdata[t][p],
                            $sformatf("test %0d port %0d rdata", t + 1, p));
                check_value(got_err[p], t_err[t][p],
                            $sformatf("test %0d port %0d err", t + 1, p));
            end
        end
    endtask

    // time limit scales with the number of test lines
    initial begin
        wait (n_tests > 0);
        #((40 * n_tests + 10) * CLK_PERIOD);
        $display("timeout: responses missing after %0d cycles", 40 * n_tests + 10);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int gap;
        clk           = 1'b0;
        reset         = 1'b1;
        p0_req_valid  = 1'b0;
        p0_req_op     = 3'd0;
        p0_req_base   = '0;
        p0_req_offset = '0;
        p0_req_wdata  = '0;
        p1_req_valid  = 1'b0;
        p1_req_op     = 3'd0;
        p1_req_base   = '0;
        p1_req_offset = '0;
        p1_req_wdata  = '0;
        void'($urandom(32'hd509));
        read_tests();
        if (n_tests == 0) begin
            $display("test file holds no test lines");
            $display("SIMULATION FAILED");
            $fatal(1, "nothing to run");
        end else begin
            repeat (2) @(posedge clk);
            #1;
            reset = 1'b0;
            for (int t = 0; t < n_tests; t++) begin
                gap = $urandom % 4;
                repeat (gap) @(posedge clk);
                @(posedge clk);
                #1;
                want_cnt[0] = resp_cnt[0] + (t_en[t][0] ? 1 : 0);
                want_cnt[1] = resp_cnt[1] + (t_en[t][1] ? 1 : 0);
                launch_pair(t);
                wait (resp_cnt[0] >= want_cnt[0] && resp_cnt[1] >= want_cnt[1]);
                check_results(t);
            end
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

/* compile.f */
+incdir+source
source/lsu_pkg.sv
source/load_extract.sv
source/store_align.sv
source/agu.sv
source/lsu_port.sv
source/axil_arbiter.sv
source/data_ram.sv
source/mem_subsys_top.sv
verification/tb_mem_subsys.sv

/* verification/mem_tests.txt */
# per port, port 0 then port 1: en op base offset wdata exp_rdata exp_err (hex)
# op 0..7 = lb lbu lh lhu lw sb sh sw, err 0 none 1 load align 2 store align 3 bus
1 7 00000100 00000000 12345678 00000000 0 1 7 00000200 00000000 cafef00d 00000000 0
1 4 00000100 00000000 00000000 12345678 0 1 4 00000200 00000000 00000000 cafef00d 0
1 5 00000040 00000000 000000a1 00000000 0 1 6 00000080 00000002 00008001 00000000 0
1 5 00000040 00000001 000000b2 00000000 0 1 6 00000080 00000000 00007ffe 00000000 0
1 5 00000040 00000002 ffffffc3 00000000 0 0 0 00000000 00000000 00000000 00000000 0
1 5 00000040 00000003 00000054 00000000 0 1 4 00000080 00000000 00000000 80017ffe 0
1 4 00000040 00000000 00000000 54c3b2a1 0 1 2 00000080 00000002 00000000 ffff8001 0
1 0 00000040 00000002 00000000 ffffffc3 0 1 3 00000080 00000002 00000000 00008001 0
1 1 00000040 00000002 00000000 000000c3 0 1 2 00000080 00000000 00000000 00007ffe 0
1 0 00000040 00000003 00000000 00000054 0 1 1 00000080 00000001 00000000 0000007f 0
1 2 00000040 00000000 00000000 ffffb2a1 0 1 0 00000080 00000003 00000000 ffffff80 0
1 6 00000100 00000001 0000dead 00000000 2 1 4 00000200 00000002 00000000 00000000 1
1 7 00000100 00000003 ffffffff 00000000 2 1 2 00000200 00000003 00000000 00000000 1
1 4 00000100 00000000 00000000 12345678 0 1 3 00000040 00000001 00000000 00000000 1
1 7 00000400 00000000 11112222 00000000 3 1 0 00001000 00000000 00000000 00000000 3
1 4 00000000 00000000 00000000 00000000 0 1 4 00000400 00000000 00000000 00000000 3
1 4 00000104 fffffffc 00000000 12345678 0 1 5 00000204 ffffffff 00000099 00000000 0
1 7 000003fc 00000000 a5a55a5a 00000000 0 1 4 00000204 fffffffc 00000000 99fef00d 0
1 4 000003fc 00000000 00000000 a5a55a5a 0 0 0 00000000 00000000 00000000 00000000 0
